// ==== source/frame_geom_pkg.sv ====
`default_nettype none

package frame_geom_pkg;

	// visible frame size in pixels
	localparam int frame_width  = 640;
	localparam int frame_height = 480;

	// coordinate widths, wide enough for 639 and 479
	localparam int col_bits = 10;
	localparam int row_bits = 9;

	// a memory index is the row and column side by side
	localparam int addr_index_bits = row_bits + col_bits;

	typedef logic [col_bits-1:0] col_t;
	typedef logic [row_bits-1:0] row_t;

	// coordinates of the final pixel of a frame
	localparam col_t last_col = col_t'(frame_width - 1);
	localparam row_t last_row = row_t'(frame_height - 1);

	// pixel address
	// built from row and column, consumed as a flat index by the memories
	// column slots 640..1023 of each row are never touched
	typedef union packed {
		struct packed {
			row_t row;
			col_t col;
		} coord;
		logic [addr_index_bits-1:0] index;
	} pixel_addr_t;

endpackage

`default_nettype wire

// ==== source/pixel_pkg.sv ====
`default_nettype none

package pixel_pkg;

	// one bit each of red, green, blue
	localparam int color_bits = 3;

	typedef logic [color_bits-1:0] color_t;

	// selects one of the two frame memories
	typedef logic buffer_id_t;

	// buffer the rasterizer owns after reset, the other one is shown
	localparam buffer_id_t reset_back_buffer = 1'b0;

endpackage

`default_nettype wire

// ==== source/frame_cell.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_cell (
	input  wire                        clk,
	input  wire                        write_enable,
	input  frame_geom_pkg::pixel_addr_t write_addr,
	input  pixel_pkg::color_t          write_color,
	input  frame_geom_pkg::pixel_addr_t read_addr,
	output pixel_pkg::color_t          read_data
);

	import frame_geom_pkg::*;
	import pixel_pkg::*;

	// full 2^19 space, rows padded out to 1024 columns
	localparam int depth = 2 ** addr_index_bits;

	color_t mem [depth];

	// write port, rasterizer side
	always_ff @(posedge clk) begin
		if (write_enable) begin
			mem[write_addr.index] <= write_color;
		end
	end

	// read port, display side
	// data comes back one cycle after the address
	always_ff @(posedge clk) begin
		read_data <= mem[read_addr.index];
	end

endmodule

`default_nettype wire

// ==== source/raster_intake.sv ====
`timescale 1ns/1ps
`default_nettype none

module raster_intake (
	input  wire                         rast_pixel_rdy,
	input  frame_geom_pkg::col_t        rast_col,
	input  frame_geom_pkg::row_t        rast_row,
	input  pixel_pkg::color_t           rast_color,
	input  wire                         rast_accept,
	input  pixel_pkg::buffer_id_t       back_buffer,
	output logic                        write_enable_0,
	output logic                        write_enable_1,
	output frame_geom_pkg::pixel_addr_t write_addr,
	output pixel_pkg::color_t           write_color,
	output logic                        last_pixel
);

	import frame_geom_pkg::*;
	import pixel_pkg::*;

	// strobe that actually lands in a memory
	logic pixel_write;

	// writes are dropped while a swap is pending
	assign pixel_write = rast_pixel_rdy && rast_accept;

	// steer to whichever cell is currently the back buffer
	assign write_enable_0 = pixel_write && (back_buffer == buffer_id_t'(1'b0));
	assign write_enable_1 = pixel_write && (back_buffer == buffer_id_t'(1'b1));

	// address from row/column, cells see the flat index
	always_comb begin
		write_addr.coord.row = rast_row;
		write_addr.coord.col = rast_col;
	end

	// same color goes to both cells, only one is enabled
	assign write_color = rast_color;

	// final coordinates of the frame
	// checked on the raw strobe, so a held-off write still triggers the swap
	assign last_pixel = rast_pixel_rdy
		&& (rast_col == last_col)
		&& (rast_row == last_row);

endmodule

`default_nettype wire

// ==== source/buffer_swap_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module buffer_swap_ctrl (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   next_frame_switch,
	input  wire                   rast_done,
	input  wire                   last_pixel,
	output pixel_pkg::buffer_id_t back_buffer,
	output logic                  rast_accept
);

	import pixel_pkg::*;

	// buffer that becomes the back buffer at the next commit
	// equal to back_buffer when nothing is pending
	buffer_id_t target;

	// a swap is pending while the two differ
	assign rast_accept = (target == back_buffer);

	// commit on the final pixel of the frame being drawn
	// front and back trade places one cycle after last_pixel
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			back_buffer <= reset_back_buffer;
		end else if (!rast_accept && last_pixel) begin
			back_buffer <= target;
		end
	end

	// switch request from the clipping unit
	// with rast_done the front buffer becomes the target
	// without it the target falls back, so any pending swap is dropped
	// and the old frame keeps being shown
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			target <= reset_back_buffer;
		end else if (next_frame_switch && rast_done) begin
			target <= ~back_buffer;
		end else if (next_frame_switch) begin
			target <= back_buffer;
		end
	end

endmodule

`default_nettype wire

// ==== source/scanout.sv ====
`timescale 1ns/1ps
`default_nettype none

module scanout (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire                         dvi_fifo_full,
	input  pixel_pkg::buffer_id_t       back_buffer,
	input  pixel_pkg::color_t           read_data_0,
	input  pixel_pkg::color_t           read_data_1,
	output frame_geom_pkg::pixel_addr_t read_addr,
	output pixel_pkg::color_t           dvi_color,
	output logic                        dvi_fifo_write_enable
);

	import frame_geom_pkg::*;
	import pixel_pkg::*;

	// raster position of the pixel being fetched
	col_t scan_col;
	row_t scan_row;

	// front buffer as seen when the fetch was issued
	buffer_id_t read_buffer;

	// the FIFO has room, so this address is consumed now
	logic advance;

	assign advance = !dvi_fifo_full;

	// column counter, wraps at the end of each line
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			scan_col <= '0;
		end else if (advance) begin
			if (scan_col == last_col) begin
				scan_col <= '0;
			end else begin
				scan_col <= scan_col + col_t'(1);
			end
		end
	end

	// row counter, steps at end of line and wraps at end of frame
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			scan_row <= '0;
		end else if (advance && (scan_col == last_col)) begin
			if (scan_row == last_row) begin
				scan_row <= '0;
			end else begin
				scan_row <= scan_row + row_t'(1);
			end
		end
	end

	always_comb begin
		read_addr.coord.row = scan_row;
		read_addr.coord.col = scan_col;
	end

	// buffer number and strobe travel with the memory read latency
	// a swap lands on a pixel boundary, never inside one fetch
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			read_buffer           <= ~reset_back_buffer;
			dvi_fifo_write_enable <= 1'b0;
		end else begin
			read_buffer           <= ~back_buffer;
			dvi_fifo_write_enable <= advance;
		end
	end

	// pick the cell that was front when the address went out
	assign dvi_color = (read_buffer == buffer_id_t'(1'b1)) ? read_data_1 : read_data_0;

endmodule

`default_nettype wire

// ==== source/frame_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_buffer (
	input  wire                  clk,
	input  wire                  rst_n,

	// rasterizer
	input  wire                  rast_pixel_rdy,
	input  pixel_pkg::color_t    rast_color,
	input  frame_geom_pkg::col_t rast_col,
	input  frame_geom_pkg::row_t rast_row,
	input  wire                  rast_done,
	output logic                 rast_accept,

	// clipping unit, single-cycle pulse
	input  wire                  next_frame_switch,

	// DVI FIFO
	input  wire                  dvi_fifo_full,
	output pixel_pkg::color_t    dvi_color,
	output logic                 dvi_fifo_write_enable
);

	import frame_geom_pkg::*;
	import pixel_pkg::*;

	// rasterizer write path
	logic        write_enable_0;
	logic        write_enable_1;
	pixel_addr_t write_addr;
	color_t      write_color;
	logic        last_pixel;

	// buffer currently owned by the rasterizer
	buffer_id_t  back_buffer;

	// display read path, shared address into both cells
	pixel_addr_t read_addr;
	color_t      read_data_0;
	color_t      read_data_1;

	raster_intake intake (
		.rast_pixel_rdy (rast_pixel_rdy),
		.rast_col       (rast_col),
		.rast_row       (rast_row),
		.rast_color     (rast_color),
		.rast_accept    (rast_accept),
		.back_buffer    (back_buffer),
		.write_enable_0 (write_enable_0),
		.write_enable_1 (write_enable_1),
		.write_addr     (write_addr),
		.write_color    (write_color),
		.last_pixel     (last_pixel)
	);

	buffer_swap_ctrl swap_ctrl (
		.clk               (clk),
		.rst_n             (rst_n),
		.next_frame_switch (next_frame_switch),
		.rast_done         (rast_done),
		.last_pixel        (last_pixel),
		.back_buffer       (back_buffer),
		.rast_accept       (rast_accept)
	);

	frame_cell cell_0 (
		.clk          (clk),
		.write_enable (write_enable_0),
		.write_addr   (write_addr),
		.write_color  (write_color),
		.read_addr    (read_addr),
		.read_data    (read_data_0)
	);

	frame_cell cell_1 (
		.clk          (clk),
		.write_enable (write_enable_1),
		.write_addr   (write_addr),
		.write_color  (write_color),
		.read_addr    (read_addr),
		.read_data    (read_data_1)
	);

	// reads the buffer that is not the back buffer
	scanout scan (
		.clk                   (clk),
		.rst_n                 (rst_n),
		.dvi_fifo_full         (dvi_fifo_full),
		.back_buffer           (back_buffer),
		.read_data_0           (read_data_0),
		.read_data_1           (read_data_1),
		.read_addr             (read_addr),
		.dvi_color             (dvi_color),
		.dvi_fifo_write_enable (dvi_fifo_write_enable)
	);

endmodule

`default_nettype wire

// ==== verification/frame_buffer_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_buffer_checker (
	input wire                        clk,
	input wire                        rst_n,
	input wire                        last_pixel,
	input wire pixel_pkg::buffer_id_t back_buffer,
	input wire pixel_pkg::buffer_id_t target,
	input wire                        rast_accept,
	input wire                        next_frame_switch,
	input wire                        rast_done,
	input wire                        dvi_fifo_full,
	input wire                        dvi_fifo_write_enable
);

	import pixel_pkg::*;

	// count of failed assertions, the testbench polls it
	int failures = 0;

	// front and back trade places only on the edge after a final pixel with a swap pending
	swap_on_last_pixel: assert property (@(posedge clk) disable iff (!rst_n)
		!$stable(back_buffer) |-> $past(last_pixel && (target != back_buffer)))
		else begin
			failures++;
			$error("back_buffer changed without a pending swap and a final pixel");
		end

	// rasterizer is held off only from the edge after a switch pulse with rast_done
	accept_drops_on_switch: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(rast_accept) |-> $past(next_frame_switch && rast_done))
		else begin
			failures++;
			$error("rast_accept fell without a switch pulse with rast_done");
		end

	// a strobe needs room in the FIFO one cycle earlier
	strobe_after_room: assert property (@(posedge clk) disable iff (!rst_n)
		dvi_fifo_write_enable |-> $past(!dvi_fifo_full))
		else begin
			failures++;
			$error("dvi_fifo_write_enable high after a cycle with the FIFO full");
		end

endmodule

`default_nettype wire

// ==== verification/frame_buffer_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_buffer_tb;

	import frame_geom_pkg::*;
	import pixel_pkg::*;

	localparam int frame_pixels = frame_width * frame_height;
	// six frames, two cycles per pixel
	localparam int planned_frames = 6;
	localparam int watchdog_cycles = planned_frames * frame_pixels * 2;

	logic   clk = 1'b0;
	logic   rst_n;
	logic   rast_pixel_rdy;
	color_t rast_color;
	col_t   rast_col;
	row_t   rast_row;
	logic   rast_done;
	logic   rast_accept;
	logic   next_frame_switch;
	logic   dvi_fifo_full;
	color_t dvi_color;
	logic   dvi_fifo_write_enable;

	integer seed = 32'he4fa1578;
	logic   backpressure = 1'b0;
	int     fail_count = 0;
	int     compared = 0;

	// model state, mirrors the DUT right after each rising edge
	color_t      model_mem [2][1 << addr_index_bits];
	buffer_id_t  model_back = 1'b0;
	buffer_id_t  model_target = 1'b0;
	pixel_addr_t model_scan = '0;
	logic        exp_write_enable = 1'b0;
	color_t      exp_color;

	frame_buffer uut (
		.clk(clk), .rst_n(rst_n),
		.rast_pixel_rdy(rast_pixel_rdy), .rast_color(rast_color),
		.rast_col(rast_col), .rast_row(rast_row),
		.rast_done(rast_done), .rast_accept(rast_accept),
		.next_frame_switch(next_frame_switch), .dvi_fifo_full(dvi_fifo_full),
		.dvi_color(dvi_color), .dvi_fifo_write_enable(dvi_fifo_write_enable)
	);

	// swap side, FIFO inputs tied so the strobe rule is vacuous there
	bind buffer_swap_ctrl frame_buffer_checker swap_checks (
		.clk(clk), .rst_n(rst_n), .last_pixel(last_pixel),
		.back_buffer(back_buffer), .target(target), .rast_accept(rast_accept),
		.next_frame_switch(next_frame_switch), .rast_done(rast_done),
		.dvi_fifo_full(1'b1), .dvi_fifo_write_enable(1'b0)
	);

	// display side, swap inputs tied to a quiet state
	bind scanout frame_buffer_checker scan_checks (
		.clk(clk), .rst_n(rst_n), .last_pixel(1'b0),
		.back_buffer(1'b0), .target(1'b0), .rast_accept(1'b1),
		.next_frame_switch(1'b0), .rast_done(1'b0),
		.dvi_fifo_full(dvi_fifo_full), .dvi_fifo_write_enable(dvi_fifo_write_enable)
	);

	always #10 clk = ~clk;

	// expected pixel for a fetch from the given front buffer
	function automatic color_t expected_color(input pixel_addr_t addr, input buffer_id_t front);
		return model_mem[front][addr.index];
	endfunction

	// row-major successor, wraps at column 639 and row 479
	function automatic pixel_addr_t next_scan(input pixel_addr_t addr);
		pixel_addr_t n;
		n = addr;
		if (addr.coord.col == last_col) begin
			n.coord.col = '0;
			n.coord.row = (addr.coord.row == last_row) ? row_t'(0) : addr.coord.row + row_t'(1);
		end else begin
			n.coord.col = addr.coord.col + col_t'(1);
		end
		return n;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			fail_count++;
			$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, expected);
			$display("sim failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	// outputs are settled at the falling edge, inputs were driven after the rising one
	always @(negedge clk) begin : compare
		logic       accept;
		logic       last;
		buffer_id_t next_back;
		check_value("dvi_fifo_write_enable", dvi_fifo_write_enable, exp_write_enable);
		// unwritten locations are X in both the DUT and the model
		if (exp_write_enable && !$isunknown(exp_color)) begin
			check_value("dvi_color", dvi_color, exp_color);
			compared++;
		end
		check_value("rast_accept", rast_accept, model_target == model_back);
		check_value("back_buffer", uut.back_buffer, model_back);
		check_value("assertion failures",
			uut.swap_ctrl.swap_checks.failures + uut.scan.scan_checks.failures, 0);
		// predict the coming edge
		if (!rst_n) begin
			model_back = 1'b0;
			model_target = 1'b0;
			model_scan = '0;
			exp_write_enable = 1'b0;
		end else begin
			// fetch reads memory as it was before this edge's write
			exp_write_enable = !dvi_fifo_full;
			if (!dvi_fifo_full) begin
				exp_color = expected_color(model_scan, ~model_back);
				model_scan = next_scan(model_scan);
			end
			accept = (model_target == model_back);
			last = rast_pixel_rdy && (rast_col == last_col) && (rast_row == last_row);
			if (rast_pixel_rdy && accept) begin
				model_mem[model_back][{rast_row, rast_col}] = rast_color;
			end
			next_back = (!accept && last) ? model_target : model_back;
			if (next_frame_switch) begin
				model_target = rast_done ? ~model_back : model_back;
			end
			model_back = next_back;
		end
	end

	// one cycle, inputs change 2 ns after the rising edge
	task automatic step();
		@(posedge clk);
		#2;
		rast_pixel_rdy = 1'b0;
		next_frame_switch = 1'b0;
		dvi_fifo_full = backpressure && (($unsigned($random(seed)) % 100) < 30);
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (16) step();
		rst_n = 1'b1;
	endtask

	// raster-order pixels with random colors
	task automatic draw_pixels(input int first, input int count);
		int idx;
		for (int i = 0; i < count; i++) begin
			idx = first + i;
			step();
			rast_pixel_rdy = 1'b1;
			rast_row = row_t'(idx / frame_width);
			rast_col = col_t'(idx % frame_width);
			rast_color = color_t'($random(seed));
		end
	endtask

	task automatic pulse_switch(input logic done);
		step();
		next_frame_switch = 1'b1;
		rast_done = done;
	endtask

	initial begin
		rst_n = 1'b0;
		rast_pixel_rdy = 1'b0;
		rast_color = '0;
		rast_col = '0;
		rast_row = '0;
		rast_done = 1'b0;
		next_frame_switch = 1'b0;
		dvi_fifo_full = 1'b0;
		apply_reset();
		check_value("rast_accept", rast_accept, 1'b1);
		check_value("dvi_fifo_write_enable", dvi_fifo_write_enable, 1'b0);
		// buffer 0, nothing pending so the final pixel just writes
		draw_pixels(0, frame_pixels);
		// swap, then fill buffer 1 while buffer 0 scans out in full
		pulse_switch(1'b1);
		draw_pixels(frame_pixels - 1, 1);
		draw_pixels(0, frame_pixels);
		pulse_switch(1'b1);
		draw_pixels(frame_pixels - 1, 1);
		backpressure = 1'b1;
		// partial frame then a pending swap, the rest is dropped
		draw_pixels(0, 1000);
		pulse_switch(1'b1);
		draw_pixels(1000, frame_pixels - 1000);
		repeat (frame_pixels * 3 / 2) step();
		// switch without rast_done, then a pending swap that gets cancelled
		pulse_switch(1'b0);
		pulse_switch(1'b1);
		pulse_switch(1'b0);
		draw_pixels(frame_pixels - 1, 1);
		repeat (frame_pixels * 3 / 2) step();
		// memories survive reset, scan restarts at (0, 0) of buffer 1
		backpressure = 1'b0;
		apply_reset();
		repeat (100) step();
		check_value("compared pixel count above zero", compared > 0, 1'b1);
		if (fail_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	initial begin : watchdog
		repeat (watchdog_cycles) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles", watchdog_cycles);
		$display("sim failed");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// ==== flist.f ====
source/frame_geom_pkg.sv
source/pixel_pkg.sv
source/frame_cell.sv
source/raster_intake.sv
source/buffer_swap_ctrl.sv
source/scanout.sv
source/frame_buffer.sv
verification/frame_buffer_checker.sv
verification/frame_buffer_tb.sv

// ==== Bender.yml ====
package:
  name: frame_buffer

sources:
  # packages first, then leaf modules, then the top level
  - source/frame_geom_pkg.sv
  - source/pixel_pkg.sv
  - source/frame_cell.sv
  - source/raster_intake.sv
  - source/buffer_swap_ctrl.sv
  - source/scanout.sv
  - source/frame_buffer.sv

  - target: test
    files:
      - verification/frame_buffer_checker.sv
      - verification/frame_buffer_tb.sv
